/* design/mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int ALU_OP_W  = 8;
    localparam int ALU_SEL_W = 3;

    // alu operation codes
    localparam logic [ALU_OP_W-1:0] EXE_NOP_OP   = 8'b0000_0000;
    localparam logic [ALU_OP_W-1:0] EXE_AND_OP   = 8'b0010_0100;
    localparam logic [ALU_OP_W-1:0] EXE_OR_OP    = 8'b0010_0101;
    localparam logic [ALU_OP_W-1:0] EXE_XOR_OP   = 8'b0010_0110;
    localparam logic [ALU_OP_W-1:0] EXE_NOR_OP   = 8'b0010_0111;
    localparam logic [ALU_OP_W-1:0] EXE_SLL_OP   = 8'b0111_1100;
    localparam logic [ALU_OP_W-1:0] EXE_SRL_OP   = 8'b0000_0010;
    localparam logic [ALU_OP_W-1:0] EXE_SRA_OP   = 8'b0000_0011;
    localparam logic [ALU_OP_W-1:0] EXE_MOVZ_OP  = 8'b0000_1010;
    localparam logic [ALU_OP_W-1:0] EXE_MOVN_OP  = 8'b0000_1011;
    localparam logic [ALU_OP_W-1:0] EXE_MFHI_OP  = 8'b0001_0000;
    localparam logic [ALU_OP_W-1:0] EXE_MTHI_OP  = 8'b0001_0001;
    localparam logic [ALU_OP_W-1:0] EXE_MFLO_OP  = 8'b0001_0010;
    localparam logic [ALU_OP_W-1:0] EXE_MTLO_OP  = 8'b0001_0011;
    localparam logic [ALU_OP_W-1:0] EXE_SLT_OP   = 8'b0010_1010;
    localparam logic [ALU_OP_W-1:0] EXE_SLTU_OP  = 8'b0010_1011;
    localparam logic [ALU_OP_W-1:0] EXE_ADD_OP   = 8'b0010_0000;
    localparam logic [ALU_OP_W-1:0] EXE_ADDU_OP  = 8'b0010_0001;
    localparam logic [ALU_OP_W-1:0] EXE_SUB_OP   = 8'b0010_0010;
    localparam logic [ALU_OP_W-1:0] EXE_SUBU_OP  = 8'b0010_0011;
    localparam logic [ALU_OP_W-1:0] EXE_ADDI_OP  = 8'b0101_0101;
    localparam logic [ALU_OP_W-1:0] EXE_ADDIU_OP = 8'b0101_0110;

    // result select, 3'b101 stays free for multiply
    localparam logic [ALU_SEL_W-1:0] EXE_RES_NOP         = 3'b000;
    localparam logic [ALU_SEL_W-1:0] EXE_RES_LOGIC       = 3'b001;
    localparam logic [ALU_SEL_W-1:0] EXE_RES_SHIFT       = 3'b010;
    localparam logic [ALU_SEL_W-1:0] EXE_RES_MOVE        = 3'b011;
    localparam logic [ALU_SEL_W-1:0] EXE_RES_ARITHMETIC  = 3'b100;
    localparam logic [ALU_SEL_W-1:0] EXE_RES_JUMP_BRANCH = 3'b110;

endpackage

/* design/mips_dp_pkg.sv */
package mips_dp_pkg;

    // datapath word
    localparam int REG_W = 32;

    // general register index
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_W-1:0] ZERO_WORD = '0;

endpackage

/* design/ex_if.sv */
interface ex_issue_if;
    import mips_isa_pkg::*;
    import mips_dp_pkg::*;

    logic [ALU_OP_W-1:0]   aluop;
    logic [ALU_SEL_W-1:0]  alusel;
    logic [REG_W-1:0]      reg1;
    logic [REG_W-1:0]      reg2;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic [REG_W-1:0]      link_address;

    modport src (output aluop, alusel, reg1, reg2, wd, wreg, link_address);
    modport dst (input aluop, alusel, reg1, reg2, wd, wreg, link_address);
endinterface

interface ex_result_if;
    import mips_dp_pkg::*;

    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    logic [REG_W-1:0]      wdata;
    logic                  whilo;
    logic [REG_W-1:0]      hi;
    logic [REG_W-1:0]      lo;

    modport src (output wd, wreg, wdata, whilo, hi, lo);
    modport dst (input wd, wreg, wdata, whilo, hi, lo);
endinterface

interface hilo_fwd_if;
    import mips_dp_pkg::*;

    logic [REG_W-1:0] hi;   // architectural pair
    logic [REG_W-1:0] lo;
    logic             mem_whilo;
    logic [REG_W-1:0] mem_hi;
    logic [REG_W-1:0] mem_lo;
    logic             wb_whilo;
    logic [REG_W-1:0] wb_hi;
    logic [REG_W-1:0] wb_lo;

    modport arch (output hi, lo);
    modport pipe (output mem_whilo, mem_hi, mem_lo, wb_whilo, wb_hi, wb_lo);
    modport ex (input hi, lo, mem_whilo, mem_hi, mem_lo, wb_whilo, wb_hi, wb_lo);
endinterface

/* design/ex_issue_reg.sv */
module ex_issue_reg (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [mips_isa_pkg::ALU_OP_W-1:0]  aluop_i,
    input  logic [mips_isa_pkg::ALU_SEL_W-1:0] alusel_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg1_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg2_i,
    input  logic [mips_dp_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                               wreg_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      link_address_i,
    ex_issue_if.src                            iss
);
    import mips_isa_pkg::*;

    // control, reset to a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            iss.aluop  <= EXE_NOP_OP;
            iss.alusel <= EXE_RES_NOP;
            iss.wreg   <= 1'b0;
        end else begin
            iss.aluop  <= aluop_i;
            iss.alusel <= alusel_i;
            iss.wreg   <= wreg_i;
        end
    end

    // operands and destination
    always_ff @(posedge clk_i) begin
        iss.reg1         <= reg1_i;
        iss.reg2         <= reg2_i;
        iss.wd           <= wd_i;
        iss.link_address <= link_address_i;
    end

endmodule

/* design/ex.sv */
module ex (
    ex_issue_if.dst  iss,
    hilo_fwd_if.ex   fwd,
    ex_result_if.src res
);
    import mips_isa_pkg::*;
    import mips_dp_pkg::*;

    logic [REG_W-1:0] logicout;
    logic [REG_W-1:0] shiftres;
    logic [REG_W-1:0] moveres;
    logic [REG_W-1:0] arithmeticres;
    logic [REG_W-1:0] reg2_mux;
    logic [REG_W-1:0] result_sum;
    logic             reg1_lt_reg2;
    logic [REG_W-1:0] hi;
    logic [REG_W-1:0] lo;
    logic [4:0]       shamt;

    assign shamt = iss.reg1[4:0];

    // one adder for add, sub and slt
    assign reg2_mux = ((iss.aluop == EXE_SUB_OP) || (iss.aluop == EXE_SUBU_OP) ||
                       (iss.aluop == EXE_SLT_OP)) ? (~iss.reg2) + 1'b1 : iss.reg2;
    assign result_sum = iss.reg1 + reg2_mux;

    always_comb begin
        if (iss.aluop == EXE_SLT_OP) begin
            reg1_lt_reg2 = (iss.reg1[REG_W-1] && !iss.reg2[REG_W-1]) ||
                           (iss.reg1[REG_W-1] == iss.reg2[REG_W-1] && result_sum[REG_W-1]);
        end else begin
            reg1_lt_reg2 = iss.reg1 < iss.reg2;   // sltu
        end
    end

    always_comb begin
        case (iss.aluop)
            EXE_OR_OP:  logicout = iss.reg1 | iss.reg2;
            EXE_AND_OP: logicout = iss.reg1 & iss.reg2;
            EXE_NOR_OP: logicout = ~(iss.reg1 | iss.reg2);
            EXE_XOR_OP: logicout = iss.reg1 ^ iss.reg2;
            default:    logicout = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (iss.aluop)
            EXE_SLL_OP: shiftres = iss.reg2 << shamt;
            EXE_SRL_OP: shiftres = iss.reg2 >> shamt;
            EXE_SRA_OP: shiftres = $unsigned($signed(iss.reg2) >>> shamt);
            default:    shiftres = ZERO_WORD;
        endcase
    end

    always_comb begin
        case (iss.aluop)
            EXE_SLT_OP, EXE_SLTU_OP: begin
                arithmeticres = {{(REG_W-1){1'b0}}, reg1_lt_reg2};
            end
            EXE_ADD_OP, EXE_ADDU_OP, EXE_ADDI_OP, EXE_ADDIU_OP,
            EXE_SUB_OP, EXE_SUBU_OP: begin
                arithmeticres = result_sum;
            end
            default: begin
                arithmeticres = ZERO_WORD;
            end
        endcase
    end

    // newest hi/lo, mem before wb before arch
    always_comb begin
        if (fwd.mem_whilo) begin
            {hi, lo} = {fwd.mem_hi, fwd.mem_lo};
        end else if (fwd.wb_whilo) begin
            {hi, lo} = {fwd.wb_hi, fwd.wb_lo};
        end else begin
            {hi, lo} = {fwd.hi, fwd.lo};
        end
    end

    always_comb begin
        case (iss.aluop)
            EXE_MFHI_OP:              moveres = hi;
            EXE_MFLO_OP:              moveres = lo;
            EXE_MOVZ_OP, EXE_MOVN_OP: moveres = iss.reg1;  // condition already in wreg
            default:                  moveres = ZERO_WORD;
        endcase
    end

    always_comb begin
        res.whilo = 1'b0;
        res.hi    = ZERO_WORD;
        res.lo    = ZERO_WORD;
        if (iss.aluop == EXE_MTHI_OP) begin
            res.whilo = 1'b1;
            res.hi    = iss.reg1;
            res.lo    = lo;
        end else if (iss.aluop == EXE_MTLO_OP) begin
            res.whilo = 1'b1;
            res.hi    = hi;
            res.lo    = iss.reg1;
        end
    end

    assign res.wd   = iss.wd;
    assign res.wreg = iss.wreg;

    always_comb begin
        case (iss.alusel)
            EXE_RES_LOGIC:       res.wdata = logicout;
            EXE_RES_SHIFT:       res.wdata = shiftres;
            EXE_RES_MOVE:        res.wdata = moveres;
            EXE_RES_ARITHMETIC:  res.wdata = arithmeticres;
            EXE_RES_JUMP_BRANCH: res.wdata = iss.link_address;
            default:             res.wdata = ZERO_WORD;
        endcase
    end

endmodule

/* design/ex_wb_pipe.sv */
module ex_wb_pipe (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    ex_result_if.dst                           res,
    hilo_fwd_if.pipe                           fwd,
    output logic [mips_dp_pkg::REG_ADDR_W-1:0] wb_wd_o,
    output logic                               wb_wreg_o,
    output logic                               wb_whilo_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_wdata_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_hi_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_lo_o
);
    import mips_dp_pkg::*;

    logic [REG_ADDR_W-1:0] mem_wd;
    logic                  mem_wreg;
    logic [REG_W-1:0]      mem_wdata;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mem_wd        <= '0;
            mem_wreg      <= 1'b0;
            mem_wdata     <= ZERO_WORD;
            fwd.mem_whilo <= 1'b0;
            fwd.mem_hi    <= ZERO_WORD;
            fwd.mem_lo    <= ZERO_WORD;
            wb_wd_o       <= '0;
            wb_wreg_o     <= 1'b0;
            wb_wdata_o    <= ZERO_WORD;
            wb_whilo_o    <= 1'b0;
            wb_hi_o       <= ZERO_WORD;
            wb_lo_o       <= ZERO_WORD;
        end else begin
            // memory stage, no load/store here
            mem_wd        <= res.wd;
            mem_wreg      <= res.wreg;
            mem_wdata     <= res.wdata;
            fwd.mem_whilo <= res.whilo;
            fwd.mem_hi    <= res.hi;
            fwd.mem_lo    <= res.lo;
            // writeback stage
            wb_wd_o       <= mem_wd;
            wb_wreg_o     <= mem_wreg;
            wb_wdata_o    <= mem_wdata;
            wb_whilo_o    <= fwd.mem_whilo;
            wb_hi_o       <= fwd.mem_hi;
            wb_lo_o       <= fwd.mem_lo;
        end
    end

    assign fwd.wb_whilo = wb_whilo_o;
    assign fwd.wb_hi    = wb_hi_o;
    assign fwd.wb_lo    = wb_lo_o;

endmodule

/* design/hilo_reg.sv */
module hilo_reg (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          we_i,
    input  logic [mips_dp_pkg::REG_W-1:0] hi_i,
    input  logic [mips_dp_pkg::REG_W-1:0] lo_i,
    hilo_fwd_if.arch                      fwd,
    output logic [mips_dp_pkg::REG_W-1:0] hi_o,
    output logic [mips_dp_pkg::REG_W-1:0] lo_o
);
    import mips_dp_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= ZERO_WORD;
            lo_o <= ZERO_WORD;
        end else if (we_i) begin
            hi_o <= hi_i;   // both halves always written together
            lo_o <= lo_i;
        end
    end

    assign fwd.hi = hi_o;
    assign fwd.lo = lo_o;

endmodule

/* design/ex_top.sv */
module ex_top (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [mips_isa_pkg::ALU_OP_W-1:0]  aluop_i,
    input  logic [mips_isa_pkg::ALU_SEL_W-1:0] alusel_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg1_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg2_i,
    input  logic [mips_dp_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                               wreg_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      link_address_i,
    output logic [mips_dp_pkg::REG_ADDR_W-1:0] wb_wd_o,
    output logic                               wb_wreg_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_wdata_o,
    output logic                               wb_whilo_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_hi_o,
    output logic [mips_dp_pkg::REG_W-1:0]      wb_lo_o,
    output logic [mips_dp_pkg::REG_W-1:0]      hi_o,
    output logic [mips_dp_pkg::REG_W-1:0]      lo_o
);

    ex_issue_if  iss_if ();
    ex_result_if res_if ();
    hilo_fwd_if  fwd_if ();

    ex_issue_reg u_issue (
        .clk_i, .arst_n_i,
        .aluop_i, .alusel_i, .reg1_i, .reg2_i, .wd_i, .wreg_i, .link_address_i,
        .iss (iss_if.src)
    );

    ex u_ex (
        .iss (iss_if.dst),
        .fwd (fwd_if.ex),
        .res (res_if.src)
    );

    ex_wb_pipe u_pipe (
        .clk_i, .arst_n_i,
        .res (res_if.dst),
        .fwd (fwd_if.pipe),
        .wb_wd_o, .wb_wreg_o, .wb_whilo_o, .wb_wdata_o, .wb_hi_o, .wb_lo_o
    );

    // hi/lo commits from writeback
    hilo_reg u_hilo (
        .clk_i, .arst_n_i,
        .we_i (wb_whilo_o),
        .hi_i (wb_hi_o),
        .lo_i (wb_lo_o),
        .fwd  (fwd_if.arch),
        .hi_o,
        .lo_o
    );

endmodule

/* dv/ex_checker.sv */
module ex_checker (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic [mips_isa_pkg::ALU_OP_W-1:0]  aluop_i,
    input  logic [mips_isa_pkg::ALU_SEL_W-1:0] alusel_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg1_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      reg2_i,
    input  logic [mips_dp_pkg::REG_ADDR_W-1:0] wd_i,
    input  logic                               wreg_i,
    input  logic [mips_dp_pkg::REG_W-1:0]      link_address_i,
    input  logic [mips_dp_pkg::REG_ADDR_W-1:0] wb_wd_o,
    input  logic                               wb_wreg_o,
    input  logic [mips_dp_pkg::REG_W-1:0]      wb_wdata_o,
    input  logic                               wb_whilo_o,
    input  logic [mips_dp_pkg::REG_W-1:0]      wb_hi_o,
    input  logic [mips_dp_pkg::REG_W-1:0]      wb_lo_o,
    input  logic [mips_dp_pkg::REG_W-1:0]      hi_o,
    input  logic [mips_dp_pkg::REG_W-1:0]      lo_o,
    input  logic                               stream_done_i,
    output logic                               done_o,
    output int                                 error_count_o
);
    import mips_isa_pkg::*;
    import mips_dp_pkg::*;

    localparam int LATENCY   = 3;  // falling edges from input to writeback
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        int                    stamp;
        int                    test;
        logic [REG_ADDR_W-1:0] wd;
        logic                  wreg;
        logic [REG_W-1:0]      wdata;
        logic                  whilo;
        logic [REG_W-1:0]      hi;
        logic [REG_W-1:0]      lo;
    } exp_t;

    exp_t             pending [$];
    logic [REG_W-1:0] model_hi;  // program order
    logic [REG_W-1:0] model_lo;
    logic [REG_W-1:0] arch_hi;   // committed pair
    logic [REG_W-1:0] arch_lo;
    int               cycle;
    int               checked;
    int               checks [NUM_TESTS];
    int               errors [NUM_TESTS];

    initial begin
        done_o        = 1'b0;
        error_count_o = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
    end

    function automatic string test_label(input int t);
        case (t)
            0:       return "reset";
            1:       return "logic_shift";
            2:       return "arith_compare";
            3:       return "hilo_write";
            4:       return "hilo_move";
            default: return "link_bubble";
        endcase
    endfunction

    function automatic int classify(input logic [ALU_OP_W-1:0] op, input logic [ALU_SEL_W-1:0] sel);
        case (sel)
            EXE_RES_LOGIC, EXE_RES_SHIFT: return 1;
            EXE_RES_ARITHMETIC:           return 2;
            EXE_RES_MOVE:                 return 4;
            default:                      return (op == EXE_MTHI_OP || op == EXE_MTLO_OP) ? 3 : 5;
        endcase
    endfunction

    function automatic logic [REG_W-1:0] model_wdata(
        input logic [ALU_OP_W-1:0] op, input logic [ALU_SEL_W-1:0] sel,
        input logic [REG_W-1:0] a, input logic [REG_W-1:0] b, input logic [REG_W-1:0] link
    );
        if (sel == EXE_RES_JUMP_BRANCH) begin
            return link;
        end else if (sel == EXE_RES_NOP) begin
            return ZERO_WORD;
        end
        case (op)
            EXE_OR_OP:                                         return a | b;
            EXE_AND_OP:                                        return a & b;
            EXE_NOR_OP:                                        return ~(a | b);
            EXE_XOR_OP:                                        return a ^ b;
            EXE_SLL_OP:                                        return b << a[4:0];
            EXE_SRL_OP:                                        return b >> a[4:0];
            EXE_SRA_OP:                                        return $signed(b) >>> a[4:0];
            EXE_ADD_OP, EXE_ADDU_OP, EXE_ADDI_OP, EXE_ADDIU_OP: return a + b;
            EXE_SUB_OP, EXE_SUBU_OP:                           return a - b;
            EXE_SLT_OP:                     return REG_W'($signed(a) < $signed(b));
            EXE_SLTU_OP:                                       return REG_W'(a < b);
            EXE_MFHI_OP:                                       return model_hi;
            EXE_MFLO_OP:                                       return model_lo;
            EXE_MOVZ_OP, EXE_MOVN_OP:                          return a;
            default:                                           return ZERO_WORD;
        endcase
    endfunction

    function automatic exp_t predict();
        exp_t e;
        e.stamp = cycle;
        e.test  = classify(aluop_i, alusel_i);
        e.wd    = wd_i;
        e.wreg  = wreg_i;
        e.wdata = model_wdata(aluop_i, alusel_i, reg1_i, reg2_i, link_address_i);
        e.whilo = (aluop_i == EXE_MTHI_OP) || (aluop_i == EXE_MTLO_OP);
        e.hi    = ZERO_WORD;
        e.lo    = ZERO_WORD;
        if (aluop_i == EXE_MTHI_OP) begin
            e.hi = reg1_i;
            e.lo = model_lo;
        end else if (aluop_i == EXE_MTLO_OP) begin
            e.hi = model_hi;
            e.lo = reg1_i;
        end
        if (e.whilo) begin
            model_hi = e.hi;
            model_lo = e.lo;
        end
        return e;
    endfunction

    task automatic compare(input int t, input string what,
                           input logic [REG_W-1:0] exp, input logic [REG_W-1:0] act);
        checks[t]++;
        if (act !== exp) begin
            errors[t]++;
            error_count_o++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_label(t), what, exp, act);
        end
    endtask

    task automatic check_idle();
        compare(0, "wb_wreg_o", ZERO_WORD, REG_W'(wb_wreg_o));
        compare(0, "wb_whilo_o", ZERO_WORD, REG_W'(wb_whilo_o));
        compare(0, "wb_wdata_o", ZERO_WORD, wb_wdata_o);
        compare(0, "hi_o", ZERO_WORD, hi_o);
        compare(0, "lo_o", ZERO_WORD, lo_o);
    endtask

    task automatic check_op(input exp_t e);
        compare(e.test, "wb_wd_o", REG_W'(e.wd), REG_W'(wb_wd_o));
        compare(e.test, "wb_wreg_o", REG_W'(e.wreg), REG_W'(wb_wreg_o));
        compare(e.test, "wb_wdata_o", e.wdata, wb_wdata_o);
        compare(e.test, "wb_whilo_o", REG_W'(e.whilo), REG_W'(wb_whilo_o));
        compare(e.test, "wb_hi_o", e.hi, wb_hi_o);
        compare(e.test, "wb_lo_o", e.lo, wb_lo_o);
        compare(e.test, "hi_o", arch_hi, hi_o);  // older writes only
        compare(e.test, "lo_o", arch_lo, lo_o);
        if (e.whilo) begin
            arch_hi = e.hi;
            arch_lo = e.lo;
        end
        checked++;
    endtask

    task automatic print_summary();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("test %s: %0d checks, %0d errors", test_label(t), checks[t], errors[t]);
            total += checks[t];
        end
        $display("all tests: %0d checks, %0d errors", total, error_count_o);
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk_i) begin
        if (!arst_n_i) begin
            pending.delete();
            model_hi = ZERO_WORD;
            model_lo = ZERO_WORD;
            arch_hi  = ZERO_WORD;
            arch_lo  = ZERO_WORD;
            cycle    = 0;
            checked  = 0;
            check_idle();
        end else begin
            if (pending.size() > 0 && pending[0].stamp + LATENCY == cycle) begin
                check_op(pending.pop_front());
            end else if (checked == 0) begin
                check_idle();
            end
            if (!stream_done_i) begin
                pending.push_back(predict());
            end else if (pending.size() == 0 && !done_o) begin
                print_summary();
                done_o = 1'b1;
            end
            cycle++;
        end
    end

endmodule

/* dv/tb_ex_top.sv */
module tb_ex_top;
    import mips_isa_pkg::*;
    import mips_dp_pkg::*;

    localparam int NUM_OPS      = 3000;
    localparam int DRAIN_CYCLES = 20;

    logic                  clk_i;
    logic                  arst_n_i;
    logic [ALU_OP_W-1:0]   aluop_i;
    logic [ALU_SEL_W-1:0]  alusel_i;
    logic [REG_W-1:0]      reg1_i;
    logic [REG_W-1:0]      reg2_i;
    logic [REG_ADDR_W-1:0] wd_i;
    logic                  wreg_i;
    logic [REG_W-1:0]      link_address_i;
    logic [REG_ADDR_W-1:0] wb_wd_o;
    logic                  wb_wreg_o;
    logic [REG_W-1:0]      wb_wdata_o;
    logic                  wb_whilo_o;
    logic [REG_W-1:0]      wb_hi_o;
    logic [REG_W-1:0]      wb_lo_o;
    logic [REG_W-1:0]      hi_o;
    logic [REG_W-1:0]      lo_o;
    logic                  stream_done;
    logic                  checks_done;
    int                    error_count;

    logic [ALU_OP_W-1:0] op_list [21] = '{
        EXE_OR_OP, EXE_AND_OP, EXE_NOR_OP, EXE_XOR_OP, EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP,
        EXE_ADD_OP, EXE_ADDU_OP, EXE_ADDI_OP, EXE_ADDIU_OP, EXE_SUB_OP, EXE_SUBU_OP,
        EXE_SLT_OP, EXE_SLTU_OP, EXE_MFHI_OP, EXE_MFLO_OP, EXE_MOVZ_OP, EXE_MOVN_OP,
        EXE_MTHI_OP, EXE_MTLO_OP
    };

    always #20 clk_i = ~clk_i;

    ex_top i_ex_top (.*);

    ex_checker u_checker (
        .*,
        .stream_done_i (stream_done),
        .done_o        (checks_done),
        .error_count_o (error_count)
    );

    function automatic logic [ALU_SEL_W-1:0] select_for(input logic [ALU_OP_W-1:0] op);
        case (op)
            EXE_OR_OP, EXE_AND_OP, EXE_NOR_OP, EXE_XOR_OP:      return EXE_RES_LOGIC;
            EXE_SLL_OP, EXE_SRL_OP, EXE_SRA_OP:                 return EXE_RES_SHIFT;
            EXE_MFHI_OP, EXE_MFLO_OP, EXE_MOVZ_OP, EXE_MOVN_OP: return EXE_RES_MOVE;
            EXE_MTHI_OP, EXE_MTLO_OP, EXE_NOP_OP:               return EXE_RES_NOP;
            default:                                            return EXE_RES_ARITHMETIC;
        endcase
    endfunction

    // sign boundary values turn up often
    function automatic logic [REG_W-1:0] pick_word();
        case ($urandom % 8)
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            3:       return ZERO_WORD;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [REG_W-1:0] pick_reg1(input logic [ALU_OP_W-1:0] op);
        logic [REG_W-1:0] w;
        w = pick_word();
        if (op == EXE_SLL_OP || op == EXE_SRL_OP || op == EXE_SRA_OP) begin
            case ($urandom % 3)
                0:       w[4:0] = 5'd0;
                1:       w[4:0] = 5'd31;
                default: w[4:0] = w[4:0];
            endcase
        end
        return w;
    endfunction

    task automatic issue_op(input logic [ALU_OP_W-1:0] op, input logic [ALU_SEL_W-1:0] sel,
                            input logic [REG_W-1:0] a, input logic [REG_W-1:0] b);
        logic wr;
        case (op)
            EXE_NOP_OP:               wr = (sel == EXE_RES_JUMP_BRANCH);
            EXE_MTHI_OP, EXE_MTLO_OP: wr = 1'b0;
            EXE_MOVZ_OP:              wr = (b == ZERO_WORD);  // decode resolves the move
            EXE_MOVN_OP:              wr = (b != ZERO_WORD);
            default:                  wr = 1'b1;
        endcase
        @(posedge clk_i);
        aluop_i        <= op;
        alusel_i       <= sel;
        reg1_i         <= a;
        reg2_i         <= b;
        wd_i           <= REG_ADDR_W'($urandom);
        wreg_i         <= wr;
        link_address_i <= $urandom;
    endtask

    initial begin
        int unsigned         pick;
        int                  wait_cycles;
        logic [ALU_OP_W-1:0] op;
        void'($urandom(61710));
        clk_i          = 1'b0;
        arst_n_i       = 1'b0;
        aluop_i        = EXE_NOP_OP;
        alusel_i       = EXE_RES_NOP;
        reg1_i         = ZERO_WORD;
        reg2_i         = ZERO_WORD;
        wd_i           = '0;
        wreg_i         = 1'b0;
        link_address_i = ZERO_WORD;
        stream_done    = 1'b0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // read back at distance 1, 2 and 3 from the write
        // each write carries a fresh value so a stale read shows
        for (int d = 1; d <= 3; d++) begin
            issue_op(EXE_MTHI_OP, EXE_RES_NOP, 32'h1357_9bdf ^ REG_W'(d), ZERO_WORD);
            repeat (d - 1) issue_op(EXE_NOP_OP, EXE_RES_NOP, ZERO_WORD, ZERO_WORD);
            issue_op(EXE_MFHI_OP, EXE_RES_MOVE, ZERO_WORD, ZERO_WORD);
            issue_op(EXE_MTLO_OP, EXE_RES_NOP, 32'h2468_ace0 ^ REG_W'(d), ZERO_WORD);
            repeat (d - 1) issue_op(EXE_NOP_OP, EXE_RES_NOP, ZERO_WORD, ZERO_WORD);
            issue_op(EXE_MFLO_OP, EXE_RES_MOVE, ZERO_WORD, ZERO_WORD);
        end

        for (int n = 0; n < NUM_OPS; n++) begin
            pick = $urandom % 25;
            if (pick < 21) begin
                op = op_list[pick];
                issue_op(op, select_for(op), pick_reg1(op), pick_word());
            end else if (pick < 23) begin
                issue_op(EXE_NOP_OP, EXE_RES_NOP, pick_word(), pick_word());  // bubble
            end else begin
                issue_op(EXE_NOP_OP, EXE_RES_JUMP_BRANCH, pick_word(), pick_word());
            end
        end
        issue_op(EXE_NOP_OP, EXE_RES_NOP, ZERO_WORD, ZERO_WORD);
        stream_done <= 1'b1;

        wait_cycles = 0;
        while (!checks_done && wait_cycles < DRAIN_CYCLES) begin
            @(posedge clk_i);
            wait_cycles++;
        end
        if (!checks_done) begin
            $display("timeout: the pipeline did not drain after the last operation");
            $display("TESTBENCH FAILED");
        end else if (error_count != 0) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/mips_isa_pkg.sv
design/mips_dp_pkg.sv
design/ex_if.sv
design/ex_issue_reg.sv
design/ex.sv
design/ex_wb_pipe.sv
design/hilo_reg.sv
design/ex_top.sv
dv/ex_checker.sv
dv/tb_ex_top.sv
